// File: rtl/eth_tx_pkg.sv
// addresses and ports are fixed per board; edit here and rebuild for a different board
package eth_tx_pkg;

    localparam logic [47:0] board_mac       = 48'h00_11_22_33_44_55;
    localparam logic [31:0] board_ip        = {8'd192, 8'd168, 8'd1, 8'd10};
    localparam logic [47:0] default_des_mac = 48'hff_ff_ff_ff_ff_ff;  // broadcast
    localparam logic [31:0] default_des_ip  = {8'd192, 8'd168, 8'd1, 8'd102};
    localparam logic [15:0] board_port      = 16'd1234;
    localparam logic [15:0] des_port        = 16'd5678;

    localparam logic [15:0] ip_ethertype    = 16'h0800;
    localparam logic [15:0] arp_ethertype   = 16'h0806;
    localparam logic [15:0] arp_htype       = 16'h0001;     // ethernet hardware type
    localparam logic [15:0] arp_hlen_plen   = 16'h0604;     // mac 6 bytes, ip 4 bytes
    localparam logic [15:0] ip_ver_tos      = 16'h4500;     // ipv4, 5 words, tos 0
    localparam logic [7:0]  ip_ttl          = 8'h80;
    localparam logic [7:0]  ip_proto_udp    = 8'd17;
    localparam logic [15:0] ip_flags_df     = 16'h4000;
    localparam logic [31:0] crc_poly        = 32'hedb8_8320; // reflected ethernet poly

    // 46-byte ethernet body minus ip and udp headers
    localparam logic [15:0] min_payload     = 16'd18;
    localparam logic [15:0] ip_udp_head_len = 16'd28;

    localparam logic [15:0] preamble_len    = 16'd8;
    localparam logic [15:0] eth_head_len    = 16'd14;
    localparam logic [15:0] ip_head_len     = 16'd20;
    localparam logic [15:0] udp_head_len    = 16'd8;
    localparam logic [15:0] arp_data_len    = 16'd28;       // arp fields before zero pad
    localparam logic [15:0] arp_body_len    = 16'd46;
    localparam logic [15:0] crc_len         = 16'd4;
    localparam logic [15:0] ifg_len         = 16'd12;
    localparam logic [15:0] out_pipe_delay  = 16'd2;        // sequencer to gmii_txd
    localparam logic [15:0] payload_lead    = 16'd2;        // source latency plus sample reg

    typedef enum logic [1:0] {
        kind_none = 2'd0,
        kind_arp  = 2'd1,
        kind_udp  = 2'd3
    } frame_kind_e;

    typedef enum logic [3:0] {
        st_idle,
        st_preamble,
        st_eth_head,
        st_ip_head,
        st_udp_head,
        st_payload,
        st_arp_body,
        st_crc,
        st_ifg
    } tx_state_e;

endpackage

// File: rtl/crc32_gen.sv
// reflected crc-32 from all ones; output is already inverted and valid the cycle after en
`timescale 1ns/10ps

module crc32_gen
    import eth_tx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clr,
    input  logic        en,
    input  logic [7:0]  data,
    output logic [31:0] crc
);

    logic [31:0] crc_reg;

    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ crc_poly) : (r >> 1);   // lsb first
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            crc_reg <= 32'hffff_ffff;
        end else if (en) begin
            crc_reg <= crc_byte(crc_reg, data);
        end
    end

    assign crc = ~crc_reg;

endmodule

// File: rtl/frame_request_decode.sv
// request fields are sampled only on an accepted start; zero mac or ip selects both defaults
`timescale 1ns/10ps

module frame_request_decode
    import eth_tx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tx_start,
    input  logic [1:0]  tx_kind,
    input  logic        arp_op,
    input  logic [47:0] des_mac,
    input  logic [31:0] des_ip,
    input  logic [15:0] payload_len,
    input  logic        idle,
    input  logic        frame_done,
    output frame_kind_e frame_kind,
    output logic        arp_op_r,
    output logic [47:0] dest_mac_r,
    output logic [31:0] dest_ip_r,
    output logic [15:0] payload_len_r,
    output logic [15:0] pad_len,
    output logic [15:0] ip_total_len,
    output logic [15:0] ip_ident
);

    logic        kind_ok;
    logic        accept;
    logic        use_given;
    logic [15:0] body_len;

    assign kind_ok   = (tx_kind == kind_arp) || (tx_kind == kind_udp);
    assign accept    = tx_start && idle && kind_ok;
    assign use_given = (des_mac != 48'd0) && (des_ip != 32'd0);
    assign body_len  = (payload_len >= min_payload) ? payload_len : min_payload;

    // kind of the latest accepted frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frame_kind <= kind_none;
        end else if (accept) begin
            frame_kind <= frame_kind_e'(tx_kind);
        end
    end

    // request fields, held for the whole frame
    always_ff @(posedge clk) begin
        if (accept) begin
            arp_op_r      <= arp_op;
            dest_mac_r    <= use_given ? des_mac : default_des_mac;
            dest_ip_r     <= use_given ? des_ip : default_des_ip;
            payload_len_r <= payload_len;
            pad_len       <= body_len - payload_len;       // zero when no pad
            ip_total_len  <= body_len + ip_udp_head_len;
        end
    end

    // ip identification advances once per udp frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ip_ident <= 16'd0;
        end else if (frame_done && frame_kind == kind_udp) begin
            ip_ident <= ip_ident + 16'd1;
        end
    end

endmodule

// File: rtl/ip_checksum_unit.sv
// inputs must stay stable for the 12 cycles after start; result is held until the next start
`timescale 1ns/10ps

module ip_checksum_unit
    import eth_tx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [15:0] ip_total_len,
    input  logic [15:0] ip_ident,
    input  logic [31:0] dest_ip,
    output logic [15:0] checksum
);

    logic        busy;
    logic [3:0]  step;
    logic [19:0] sum;       // ten 16-bit words cannot overflow 20 bits
    logic [15:0] word;

    // header words in wire order, checksum field as zero
    always_comb begin
        case (step)
            4'd0:    word = ip_ver_tos;
            4'd1:    word = ip_total_len;
            4'd2:    word = ip_ident;
            4'd3:    word = ip_flags_df;
            4'd4:    word = {ip_ttl, ip_proto_udp};
            4'd6:    word = board_ip[31:16];
            4'd7:    word = board_ip[15:0];
            4'd8:    word = dest_ip[31:16];
            4'd9:    word = dest_ip[15:0];
            default: word = 16'h0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step <= 4'd0;
        end else if (start) begin
            busy <= 1'b1;
            step <= 4'd1;
        end else if (busy) begin
            step <= (step == 4'd12) ? 4'd0 : step + 4'd1;
            busy <= (step != 4'd12);
        end
    end

    // steps 1..9 add, 10 and 11 fold carries, 12 stores
    always_ff @(posedge clk) begin
        if (start) begin
            sum <= {4'd0, word};                           // step is 0 here
        end else if (busy && step < 4'd10) begin
            sum <= sum + {4'd0, word};
        end else if (busy && step < 4'd12) begin
            sum <= {4'd0, sum[15:0]} + {16'd0, sum[19:16]};
        end else if (busy) begin
            checksum <= ~sum[15:0];
        end
    end

endmodule

// File: rtl/frame_sequencer.sv
// one byte per clock with no back-pressure; payload source must answer payload_req one cycle late
`timescale 1ns/10ps

module frame_sequencer
    import eth_tx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tx_start,
    input  logic [1:0]  tx_kind,
    input  frame_kind_e frame_kind,
    input  logic        arp_op_r,
    input  logic [47:0] dest_mac_r,
    input  logic [31:0] dest_ip_r,
    input  logic [15:0] payload_len_r,
    input  logic [15:0] pad_len,
    input  logic [15:0] ip_total_len,
    input  logic [15:0] ip_ident,
    input  logic [15:0] checksum,
    input  logic [7:0]  payload_data,
    output logic        idle,
    output tx_state_e   state,
    output logic [15:0] byte_cnt,
    output logic [7:0]  frame_byte,
    output logic        byte_valid,
    output logic        crc_en,
    output logic        checksum_start,
    output logic        payload_req,
    output logic        frame_done
);

    logic         accept;
    logic         end_cnt;
    logic         req_next;
    logic [15:0]  cnt_last;
    logic [15:0]  udp_len;
    logic [111:0] eth_hdr;
    logic [159:0] ip_hdr;
    logic [63:0]  udp_hdr;
    logic [223:0] arp_hdr;

    assign idle   = (state == st_idle);
    assign accept = idle && tx_start && (tx_kind == kind_arp || tx_kind == kind_udp);

    assign udp_len = payload_len_r + pad_len + udp_head_len;
    assign eth_hdr = {dest_mac_r, board_mac,
                      (frame_kind == kind_udp) ? ip_ethertype : arp_ethertype};
    assign ip_hdr  = {ip_ver_tos, ip_total_len, ip_ident, ip_flags_df,
                      ip_ttl, ip_proto_udp, checksum, board_ip, dest_ip_r};
    assign udp_hdr = {board_port, des_port, udp_len, 16'h0000};  // no udp checksum
    assign arp_hdr = {arp_htype, ip_ethertype, arp_hlen_plen,
                      8'h00, arp_op_r ? 8'h02 : 8'h01,
                      board_mac, board_ip, dest_mac_r, dest_ip_r};

    // last count of each state
    always_comb begin
        case (state)
            st_preamble: cnt_last = preamble_len - 16'd1;
            st_eth_head: cnt_last = eth_head_len - 16'd1;
            st_ip_head:  cnt_last = ip_head_len - 16'd1;
            st_udp_head: cnt_last = udp_head_len - 16'd1;
            st_payload:  cnt_last = payload_len_r + pad_len - 16'd1;
            st_arp_body: cnt_last = arp_body_len - 16'd1;
            st_crc:      cnt_last = crc_len - 16'd1;
            // wire gap starts late by the output pipeline
            st_ifg:      cnt_last = ifg_len + out_pipe_delay - 16'd1;
            default:     cnt_last = 16'd0;
        endcase
    end

    assign end_cnt        = !idle && (byte_cnt == cnt_last);
    assign checksum_start = (state == st_eth_head) && (byte_cnt == 16'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_cnt <= 16'd0;
        end else if (end_cnt || idle) begin
            byte_cnt <= 16'd0;
        end else begin
            byte_cnt <= byte_cnt + 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else if (accept) begin
            state <= st_preamble;
        end else if (end_cnt) begin
            case (state)
                st_preamble: state <= st_eth_head;
                st_eth_head: state <= (frame_kind == kind_udp) ? st_ip_head : st_arp_body;
                st_ip_head:  state <= st_udp_head;
                st_udp_head: state <= st_payload;
                st_payload:  state <= st_crc;
                st_arp_body: state <= st_crc;
                st_crc:      state <= st_ifg;
                default:     state <= st_idle;
            endcase
        end
    end

    // byte for the current slot, one cycle behind the counter
    always_ff @(posedge clk) begin
        case (state)
            st_preamble: frame_byte <= (byte_cnt == cnt_last) ? 8'hd5 : 8'h55;
            st_eth_head: frame_byte <= eth_hdr[8*(13 - byte_cnt[3:0]) +: 8];
            st_ip_head:  frame_byte <= ip_hdr[8*(19 - byte_cnt[4:0]) +: 8];
            st_udp_head: frame_byte <= udp_hdr[8*(7 - byte_cnt[2:0]) +: 8];
            st_arp_body: frame_byte <= (byte_cnt < arp_data_len) ?
                                       arp_hdr[8*(27 - byte_cnt[4:0]) +: 8] : 8'h00;
            st_payload:  frame_byte <= (byte_cnt < payload_len_r) ? payload_data : 8'h00;
            default:     frame_byte <= 8'h00;
        endcase
    end

    // request leads its slot by payload_lead cycles
    always_comb begin
        req_next = 1'b0;
        if (frame_kind == kind_udp) begin
            if (state == st_udp_head && byte_cnt >= udp_head_len - payload_lead) begin
                req_next = (byte_cnt - (udp_head_len - payload_lead)) < payload_len_r;
            end else if (state == st_payload) begin
                req_next = ({1'b0, byte_cnt} + {1'b0, payload_lead}) < {1'b0, payload_len_r};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_valid  <= 1'b0;
            crc_en      <= 1'b0;
            payload_req <= 1'b0;
            frame_done  <= 1'b0;
        end else begin
            byte_valid  <= !idle && state != st_crc && state != st_ifg;
            crc_en      <= !idle && state != st_preamble && state != st_crc && state != st_ifg;
            payload_req <= req_next;
            frame_done  <= (state == st_crc) && end_cnt;   // one pulse per frame
        end
    end

endmodule

// File: rtl/gmii_output_stage.sv
// gmii_txd lags the sequencer by two cycles; crc bytes follow the last data byte without a gap
`timescale 1ns/10ps

module gmii_output_stage
    import eth_tx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  tx_state_e   state,
    input  logic [15:0] byte_cnt,
    input  logic [7:0]  frame_byte,
    input  logic        byte_valid,
    input  logic        crc_en,
    output logic        gmii_tx_en,
    output logic [7:0]  gmii_txd
);

    tx_state_e   state_d;
    logic [1:0]  cnt_d;         // crc byte index
    logic [31:0] crc;

    crc32_gen u_crc (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (state == st_preamble),
        .en    (crc_en),
        .data  (frame_byte),
        .crc   (crc)
    );

    // align state with frame_byte
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_d <= st_idle;
            cnt_d   <= 2'd0;
        end else begin
            state_d <= state;
            cnt_d   <= byte_cnt[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gmii_tx_en <= 1'b0;
            gmii_txd   <= 8'h00;
        end else begin
            gmii_tx_en <= byte_valid || (state_d == st_crc);
            if (byte_valid) begin
                gmii_txd <= frame_byte;
            end else if (state_d == st_crc) begin
                gmii_txd <= crc[8*cnt_d +: 8];            // least significant byte first
            end else begin
                gmii_txd <= 8'h00;
            end
        end
    end

endmodule

// File: rtl/eth_tx_top.sv
// rdy is combinational; the upstream must sample it on a clock edge before raising tx_start
`timescale 1ns/10ps

module eth_tx_top
    import eth_tx_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        tx_start,
    input  logic [1:0]  tx_kind,
    input  logic        arp_op,
    input  logic [47:0] des_mac,
    input  logic [31:0] des_ip,
    input  logic [15:0] payload_len,
    input  logic [7:0]  payload_data,
    output logic        rdy,
    output logic [1:0]  busy_kind,
    output logic        payload_req,
    output logic        gmii_tx_en,
    output logic [7:0]  gmii_txd
);

    frame_kind_e frame_kind;
    tx_state_e   state;
    logic        arp_op_r;
    logic [47:0] dest_mac_r;
    logic [31:0] dest_ip_r;
    logic [15:0] payload_len_r;
    logic [15:0] pad_len;
    logic [15:0] ip_total_len;
    logic [15:0] ip_ident;
    logic [15:0] checksum;
    logic [15:0] byte_cnt;
    logic [7:0]  frame_byte;
    logic        idle;
    logic        frame_done;
    logic        checksum_start;
    logic        byte_valid;
    logic        crc_en;

    assign rdy       = !tx_start && idle;
    assign busy_kind = idle ? kind_none : frame_kind;

    frame_request_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_start      (tx_start),
        .tx_kind       (tx_kind),
        .arp_op        (arp_op),
        .des_mac       (des_mac),
        .des_ip        (des_ip),
        .payload_len   (payload_len),
        .idle          (idle),
        .frame_done    (frame_done),
        .frame_kind    (frame_kind),
        .arp_op_r      (arp_op_r),
        .dest_mac_r    (dest_mac_r),
        .dest_ip_r     (dest_ip_r),
        .payload_len_r (payload_len_r),
        .pad_len       (pad_len),
        .ip_total_len  (ip_total_len),
        .ip_ident      (ip_ident)
    );

    ip_checksum_unit u_checksum (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (checksum_start),
        .ip_total_len (ip_total_len),
        .ip_ident     (ip_ident),
        .dest_ip      (dest_ip_r),
        .checksum     (checksum)
    );

    frame_sequencer u_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .tx_start       (tx_start),
        .tx_kind        (tx_kind),
        .frame_kind     (frame_kind),
        .arp_op_r       (arp_op_r),
        .dest_mac_r     (dest_mac_r),
        .dest_ip_r      (dest_ip_r),
        .payload_len_r  (payload_len_r),
        .pad_len        (pad_len),
        .ip_total_len   (ip_total_len),
        .ip_ident       (ip_ident),
        .checksum       (checksum),
        .payload_data   (payload_data),
        .idle           (idle),
        .state          (state),
        .byte_cnt       (byte_cnt),
        .frame_byte     (frame_byte),
        .byte_valid     (byte_valid),
        .crc_en         (crc_en),
        .checksum_start (checksum_start),
        .payload_req    (payload_req),
        .frame_done     (frame_done)
    );

    gmii_output_stage u_output (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .byte_cnt   (byte_cnt),
        .frame_byte (frame_byte),
        .byte_valid (byte_valid),
        .crc_en     (crc_en),
        .gmii_tx_en (gmii_tx_en),
        .gmii_txd   (gmii_txd)
    );

endmodule

// File: test/tb_clock_gen.sv
// 4 ns clock from time zero; rst_n is low for 8 rising edges and released on a falling edge
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);                 // release away from the sampling edge
        rst_n = 1'b1;
    end

endmodule

// File: test/tb_eth_tx.sv
// expected frames use the fixed board addresses and ports; ip identification starts at zero
`timescale 1ns/10ps

module tb_eth_tx;

    localparam int num_tests = 9;

    logic        clk;
    logic        rst_n;
    logic        tx_start;
    logic [1:0]  tx_kind;
    logic        arp_op;
    logic [47:0] des_mac;
    logic [31:0] des_ip;
    logic [15:0] payload_len;
    logic [7:0]  payload_data;
    logic        rdy;
    logic [1:0]  busy_kind;
    logic        payload_req;
    logic        gmii_tx_en;
    logic [7:0]  gmii_txd;

    logic [1:0]  t_kind [num_tests];
    logic        t_op   [num_tests];
    logic [15:0] t_len  [num_tests];
    logic [47:0] t_mac  [num_tests];
    logic [31:0] t_ip   [num_tests];
    string       t_name [num_tests];

    logic [7:0]  got_q [$];         // bytes seen on gmii
    logic [7:0]  exp_q [$];
    logic [7:0]  pay_q [$];         // bytes handed to the dut
    int          req_count;
    int          errors;
    int          checks;
    int          cycles;
    int          timeout_limit;
    logic [15:0] ident_model;

    tb_clock_gen clock0 (.clk(clk), .rst_n(rst_n));

    eth_tx_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_start     (tx_start),
        .tx_kind      (tx_kind),
        .arp_op       (arp_op),
        .des_mac      (des_mac),
        .des_ip       (des_ip),
        .payload_len  (payload_len),
        .payload_data (payload_data),
        .rdy          (rdy),
        .busy_kind    (busy_kind),
        .payload_req  (payload_req),
        .gmii_tx_en   (gmii_tx_en),
        .gmii_txd     (gmii_txd)
    );

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic set_entry(input int t, input logic [1:0] kind, input logic op,
                             input logic [15:0] len, input logic [47:0] mac,
                             input logic [31:0] ip, input string name);
        t_kind[t] = kind;
        t_op[t]   = op;
        t_len[t]  = len;
        t_mac[t]  = mac;
        t_ip[t]   = ip;
        t_name[t] = name;
    endtask

    function automatic int frame_bytes(input int t);
        return (t_kind[t] == 2'd1) ? 72 :
               (t_kind[t] == 2'd3) ? 82 + ((t_len[t] > 16'd18) ? t_len[t] : 16'd18) : 0;
    endfunction

    function automatic logic [15:0] ip_checksum(input logic [15:0] total,
                                                input logic [15:0] ident,
                                                input logic [31:0] dip);
        logic [31:0] s;
        s = 32'h4500 + total + ident + 32'h4000 + 32'h8011 + 32'hc0a8 + 32'h010a
            + dip[31:16] + dip[15:0];
        s = s[15:0] + s[31:16];
        s = s[15:0] + s[31:16];       // second fold catches the last carry
        return ~s[15:0];
    endfunction

    // reflected crc-32 over exp_q from index first on
    function automatic logic [31:0] frame_crc(input int first);
        logic [31:0] c;
        c = 32'hffff_ffff;
        for (int i = first; i < exp_q.size(); i++) begin
            c = c ^ {24'd0, exp_q[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic push_field(input logic [63:0] value, input int nbytes);
        for (int i = nbytes - 1; i >= 0; i--) begin
            exp_q.push_back(value[8*i +: 8]);           // network order
        end
    endtask

    task automatic build_expected(input int t);
        logic [47:0] dmac;
        logic [31:0] dip;
        logic [15:0] body;
        logic [31:0] crc;
        exp_q.delete();
        dmac = (t_mac[t] != 0 && t_ip[t] != 0) ? t_mac[t] : 48'hff_ff_ff_ff_ff_ff;
        dip  = (t_mac[t] != 0 && t_ip[t] != 0) ? t_ip[t] : 32'hc0a8_0166;
        repeat (7) exp_q.push_back(8'h55);
        exp_q.push_back(8'hd5);
        push_field(dmac, 6);
        push_field(48'h00_11_22_33_44_55, 6);
        if (t_kind[t] == 2'd1) begin
            push_field(16'h0806, 2);
            push_field(64'h0001_0800_0604, 6);
            push_field(t_op[t] ? 16'h0002 : 16'h0001, 2);
            push_field(48'h00_11_22_33_44_55, 6);
            push_field(32'hc0a8_010a, 4);
            push_field(dmac, 6);
            push_field(dip, 4);
            repeat (18) exp_q.push_back(8'h00);
        end else begin
            body = (t_len[t] > 16'd18) ? t_len[t] : 16'd18;
            push_field(16'h0800, 2);
            push_field(32'h4500_0000 | (body + 16'd28), 4);
            push_field({ident_model, 16'h4000}, 4);
            push_field(16'h8011, 2);
            push_field(ip_checksum(body + 16'd28, ident_model, dip), 2);
            push_field(32'hc0a8_010a, 4);
            push_field(dip, 4);
            push_field({16'd1234, 16'd5678, body + 16'd8, 16'h0000}, 8);
            for (int i = 0; i < t_len[t]; i++) begin
                exp_q.push_back((i < pay_q.size()) ? pay_q[i] : 8'h00);
            end
            repeat (body - t_len[t]) exp_q.push_back(8'h00);
        end
        crc = frame_crc(8);
        push_field({crc[7:0], crc[15:8], crc[23:16], crc[31:24]}, 4);   // lsb first
    endtask

    task automatic compare_frame();
        int n;
        check_value(got_q.size(), exp_q.size(), "frame length");
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_value(got_q[i], exp_q[i], $sformatf("frame byte %0d", i));
        end
    endtask

    task automatic run_entry(input int t);
        int gap;
        got_q.delete();
        pay_q.delete();
        req_count = 0;
        while (!rdy) @(negedge clk);
        tx_kind     = t_kind[t];
        arp_op      = t_op[t];
        payload_len = t_len[t];
        des_mac     = t_mac[t];
        des_ip      = t_ip[t];
        tx_start    = 1'b1;
        @(posedge clk);
        check_value(rdy, 1'b0, "rdy while tx_start high");
        @(negedge clk);
        tx_start = 1'b0;
        if (t_kind[t] == 2'd1 || t_kind[t] == 2'd3) begin
            while (!gmii_tx_en) @(negedge clk);
            check_value(busy_kind, t_kind[t], "busy_kind during frame");
            while (gmii_tx_en) @(negedge clk);
            gap = 0;
            while (!rdy) begin
                @(negedge clk);
                gap++;
            end
            check_value(gap >= 12 && gap <= 14, 1, $sformatf("rdy back after %0d cycles", gap));
            build_expected(t);
            compare_frame();
            if (t_kind[t] == 2'd3) begin
                check_value(pay_q.size(), t_len[t], "payload bytes delivered");
                ident_model++;
            end
        end else begin
            repeat (16) begin
                @(negedge clk);
                check_value(rdy, 1'b1, "rdy for ignored kind");
                check_value(busy_kind, 2'd0, "busy_kind for ignored kind");
                check_value(gmii_tx_en, 1'b0, "gmii_tx_en for ignored kind");
                check_value(payload_req, 1'b0, "payload_req for ignored kind");
            end
            check_value(got_q.size(), 0, "bytes sent for ignored kind");
        end
        check_value(req_count, (t_kind[t] == 2'd3) ? t_len[t] : 16'd0, "payload_req cycles");
    endtask

    // answers payload_req one cycle later with a random byte
    initial begin
        logic        req_seen;
        logic [31:0] rnd;
        req_seen     = 1'b0;
        payload_data = 8'h00;
        req_count    = 0;
        forever begin
            @(negedge clk);
            if (req_seen) begin
                rnd          = $urandom;
                payload_data = rnd[7:0];
                pay_q.push_back(rnd[7:0]);
            end
            if (payload_req) begin
                req_count++;
            end
            req_seen = payload_req;
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (gmii_tx_en) begin
                got_q.push_back(gmii_txd);
            end
        end
    end

    initial begin
        cycles = 0;
        wait (timeout_limit > 0);
        while (cycles <= timeout_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_limit);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int err_before;
        int total;
        void'($urandom(32'h37a0));
        tx_start    = 1'b0;
        tx_kind     = 2'd0;
        arp_op      = 1'b0;
        des_mac     = 48'd0;
        des_ip      = 32'd0;
        payload_len = 16'd0;
        errors      = 0;
        checks      = 0;
        ident_model = 16'd0;
        set_entry(0, 2'd1, 1'b0, 16'd0,  48'h0, 32'h0, "arp request, default target");
        set_entry(1, 2'd1, 1'b1, 16'd0,  48'h02_aa_bb_cc_dd_ee, 32'hc0a8_0132, "arp reply");
        set_entry(2, 2'd3, 1'b0, 16'd40, 48'h0, 32'h0, "udp 40 bytes");
        set_entry(3, 2'd3, 1'b0, 16'd5,  48'h0, 32'h0, "udp 5 bytes, padded");
        set_entry(4, 2'd3, 1'b0, 16'd18, 48'h02_12_34_56_78_9a, 32'hc0a8_0177, "udp 18 bytes");
        set_entry(5, 2'd1, 1'b0, 16'd0,  48'h0, 32'h0, "arp between udp frames");
        set_entry(6, 2'd3, 1'b0, 16'd1,  48'h0, 32'hc0a8_0105, "udp 1 byte, ip only given");
        set_entry(7, 2'd0, 1'b0, 16'd10, 48'h0, 32'h0, "kind 0 ignored");
        set_entry(8, 2'd2, 1'b0, 16'd10, 48'h0, 32'h0, "kind 2 ignored");
        total = 8 + 40 * num_tests;              // reset plus slack per entry
        for (int t = 0; t < num_tests; t++) begin
            total += frame_bytes(t);
        end
        timeout_limit = total;

        wait (rst_n === 1'b1);
        @(negedge clk);
        check_value(rdy, 1'b1, "rdy after reset");
        check_value(busy_kind, 2'd0, "busy_kind after reset");
        check_value(gmii_tx_en, 1'b0, "gmii_tx_en after reset");
        check_value(gmii_txd, 8'h00, "gmii_txd after reset");
        check_value(payload_req, 1'b0, "payload_req after reset");
        $display("after reset: %0d errors", errors);

        for (int t = 0; t < num_tests; t++) begin
            err_before = errors;
            run_entry(t);
            $display("test %0d (%s): %0d errors", t, t_name[t], errors - err_before);
        end

        $display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: list.f
rtl/eth_tx_pkg.sv
rtl/crc32_gen.sv
rtl/frame_request_decode.sv
rtl/ip_checksum_unit.sv
rtl/frame_sequencer.sv
rtl/gmii_output_stage.sv
rtl/eth_tx_top.sv
test/tb_clock_gen.sv
test/tb_eth_tx.sv

// File: Makefile
# Verilator build and run of the Ethernet frame transmitter testbench

TOP = tb_eth_tx

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
